// ==== source/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// =========================================================================
// Core dimensions
// =========================================================================

// Data and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// First fetch address after reset
`define RESET_VECTOR 32'h0000_0000

`endif

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // =========================================================================
   // Instruction word encodings
   // =========================================================================

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_LOAD   = 7'b0000011,
      OPC_OP_IMM = 7'b0010011,
      OPC_STORE  = 7'b0100011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011
   } opcode_t;

   // funct3 of OP and OP-IMM
   typedef enum logic [2:0] {
      F3_ADD_SUB = 3'b000,
      F3_SLL     = 3'b001,
      F3_SLT     = 3'b010,
      F3_SLTU    = 3'b011,
      F3_XOR     = 3'b100,
      F3_SRL     = 3'b101,
      F3_OR      = 3'b110,
      F3_AND     = 3'b111
   } alu_funct3_t;

   // funct3 of BRANCH
   typedef enum logic [2:0] {
      F3_BEQ  = 3'b000,
      F3_BNE  = 3'b001,
      F3_BLT  = 3'b100,
      F3_BGE  = 3'b101,
      F3_BLTU = 3'b110,
      F3_BGEU = 3'b111
   } branch_funct3_t;

   // Only word loads and stores
   typedef enum logic [2:0] {
      F3_WORD = 3'b010
   } mem_funct3_t;

   typedef enum logic [6:0] {
      F7_BASE = 7'b0000000,
      F7_ALT  = 7'b0100000
   } funct7_t;

   // =========================================================================
   // Operation selects
   // =========================================================================

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL
   } alu_op_t;

   typedef enum logic [2:0] {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_LT,
      BR_GE,
      BR_LTU,
      BR_GEU
   } branch_cond_t;

endpackage

`default_nettype wire

// ==== source/core_pkg.sv ====
`include "cpu_params.svh"
`default_nettype none

package core_pkg;

   import isa_pkg::*;

   // Instruction sequencing
   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DECODE,
      ST_EXECUTE,
      ST_MEMORY,
      ST_WRITEBACK
   } ctrl_state_t;

   typedef enum logic [1:0] {
      WB_NONE,
      WB_ALU,
      WB_LOAD,
      WB_IMM
   } wb_src_t;

   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_LOAD,
      MEM_STORE
   } mem_kind_t;

   // One decoded instruction, all zero is a no-op
   typedef struct packed {
      logic [`REG_ADDR_W-1:0] rs1;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rd;
      logic [`XLEN-1:0]       imm;
      alu_op_t                alu_op;
      logic                   use_imm;
      branch_cond_t           branch_cond;
      wb_src_t                wb_src;
      mem_kind_t              mem_kind;
   } decoded_instr_t;

   // Single bus transfer, word addressed
   typedef struct packed {
      logic [`XLEN-3:0] adr;
      logic [`XLEN-1:0] wdata;
      logic             we;
   } bus_req_t;

endpackage

`default_nettype wire

// ==== source/instr_decode.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module instr_decode
   import isa_pkg::*, core_pkg::*;
(
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 en_i,
   input  wire [`XLEN-1:0]     instr_i,
   output decoded_instr_t      dec_o
);

   opcode_t          opcode;
   logic [2:0]       funct3;
   logic [6:0]       funct7;
   alu_op_t          f3_op;
   logic [`XLEN-1:0] imm_i;
   logic [`XLEN-1:0] imm_s;
   logic [`XLEN-1:0] imm_b;
   logic [`XLEN-1:0] imm_u;
   decoded_instr_t   dec_d;

   assign opcode = opcode_t'(instr_i[6:0]);
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // Sign extended immediates
   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_u = {instr_i[31:12], 12'b0};

   always_comb begin
      case (alu_funct3_t'(funct3))
         F3_ADD_SUB: f3_op = (opcode == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
         F3_SLL:     f3_op = ALU_SLL;
         F3_SLT:     f3_op = ALU_SLT;
         F3_SLTU:    f3_op = ALU_SLTU;
         F3_XOR:     f3_op = ALU_XOR;
         F3_SRL:     f3_op = ALU_SRL;
         F3_OR:      f3_op = ALU_OR;
         default:    f3_op = ALU_AND;
      endcase
   end

   always_comb begin
      dec_d = '0;
      dec_d.rs1 = instr_i[19:15];
      dec_d.rs2 = instr_i[24:20];
      dec_d.rd = instr_i[11:7];
      case (opcode)
         OPC_OP: begin
            // SRA and other funct7 values fall through as no-ops
            if (funct7 == F7_BASE || (funct7 == F7_ALT && funct3 == F3_ADD_SUB)) begin
               dec_d.alu_op = f3_op;
               dec_d.wb_src = WB_ALU;
            end
         end
         OPC_OP_IMM: begin
            if (funct3 != F3_SLL && funct3 != F3_SRL) begin
               dec_d.alu_op = f3_op;
               dec_d.use_imm = 1'b1;
               dec_d.imm = imm_i;
               dec_d.wb_src = WB_ALU;
            end
         end
         OPC_LUI: begin
            dec_d.imm = imm_u;
            dec_d.wb_src = WB_IMM;
         end
         OPC_BRANCH: begin
            dec_d.alu_op = ALU_SUB;
            dec_d.imm = imm_b;
            case (branch_funct3_t'(funct3))
               F3_BEQ:  dec_d.branch_cond = BR_EQ;
               F3_BNE:  dec_d.branch_cond = BR_NE;
               F3_BLT:  dec_d.branch_cond = BR_LT;
               F3_BGE:  dec_d.branch_cond = BR_GE;
               F3_BLTU: dec_d.branch_cond = BR_LTU;
               F3_BGEU: dec_d.branch_cond = BR_GEU;
               default: dec_d.branch_cond = BR_NONE;
            endcase
         end
         OPC_LOAD: begin
            if (funct3 == F3_WORD) begin
               dec_d.use_imm = 1'b1;
               dec_d.imm = imm_i;
               dec_d.wb_src = WB_LOAD;
               dec_d.mem_kind = MEM_LOAD;
            end
         end
         OPC_STORE: begin
            if (funct3 == F3_WORD) begin
               dec_d.use_imm = 1'b1;
               dec_d.imm = imm_s;
               dec_d.mem_kind = MEM_STORE;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dec_o <= '0;
      end else if (en_i) begin
         dec_o <= dec_d;
      end
   end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module register_file (
   input  wire                    clk,
   input  wire                    we_i,
   input  wire [`REG_ADDR_W-1:0]  rd_i,
   input  wire [`XLEN-1:0]        wdata_i,
   input  wire [`REG_ADDR_W-1:0]  rs1_i,
   input  wire [`REG_ADDR_W-1:0]  rs2_i,
   output logic [`XLEN-1:0]       rs1_val_o,
   output logic [`XLEN-1:0]       rs2_val_o
);

   // x0 has no storage
   logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

   always_ff @(posedge clk) begin
      if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   assign rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== source/alu_execute.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module alu_execute
   import isa_pkg::*, core_pkg::*;
(
   input  wire                clk,
   input  wire                en_i,
   input  wire decoded_instr_t dec_i,
   input  wire [`XLEN-1:0]    rs1_val_i,
   input  wire [`XLEN-1:0]    rs2_val_i,
   output logic [`XLEN-1:0]   result_o,
   output logic               branch_taken_o
);

   logic [`XLEN-1:0] op_b;
   logic [`XLEN-1:0] result_d;
   logic [4:0]       shamt;
   logic             eq;
   logic             lt;
   logic             ltu;
   logic             taken_d;

   assign op_b = dec_i.use_imm ? dec_i.imm : rs2_val_i;
   assign shamt = op_b[4:0];

   always_comb begin
      case (dec_i.alu_op)
         ALU_SUB:  result_d = rs1_val_i - op_b;
         ALU_AND:  result_d = rs1_val_i & op_b;
         ALU_OR:   result_d = rs1_val_i | op_b;
         ALU_XOR:  result_d = rs1_val_i ^ op_b;
         ALU_SLT:  result_d = {{(`XLEN-1){1'b0}}, $signed(rs1_val_i) < $signed(op_b)};
         ALU_SLTU: result_d = {{(`XLEN-1){1'b0}}, rs1_val_i < op_b};
         ALU_SLL:  result_d = rs1_val_i << shamt;
         ALU_SRL:  result_d = rs1_val_i >> shamt;
         default:  result_d = rs1_val_i + op_b;
      endcase
   end

   // Branch compare always uses both registers
   assign eq = (rs1_val_i == rs2_val_i);
   assign lt = ($signed(rs1_val_i) < $signed(rs2_val_i));
   assign ltu = (rs1_val_i < rs2_val_i);

   always_comb begin
      case (dec_i.branch_cond)
         BR_EQ:   taken_d = eq;
         BR_NE:   taken_d = !eq;
         BR_LT:   taken_d = lt;
         BR_GE:   taken_d = !lt;
         BR_LTU:  taken_d = ltu;
         BR_GEU:  taken_d = !ltu;
         default: taken_d = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (en_i) begin
         result_o <= result_d;
         branch_taken_o <= taken_d;
      end
   end

endmodule

`default_nettype wire

// ==== source/writeback_select.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module writeback_select
   import isa_pkg::*, core_pkg::*;
(
   input  wire decoded_instr_t dec_i,
   input  wire [`XLEN-1:0]     pc_i,
   input  wire [`XLEN-1:0]     alu_result_i,
   input  wire                 branch_taken_i,
   input  wire [`XLEN-1:0]     load_data_i,
   output logic [`XLEN-1:0]    wdata_o,
   output logic [`XLEN-1:0]    next_pc_o
);

   logic take_branch;

   always_comb begin
      case (dec_i.wb_src)
         WB_ALU:  wdata_o = alu_result_i;
         WB_LOAD: wdata_o = load_data_i;
         WB_IMM:  wdata_o = dec_i.imm;
         default: wdata_o = '0;
      endcase
   end

   // Taken flag only counts for real branches
   assign take_branch = branch_taken_i && (dec_i.branch_cond != BR_NONE);
   assign next_pc_o = take_branch ? (pc_i + dec_i.imm) : (pc_i + 'd4);

endmodule

`default_nettype wire

// ==== source/wb_master.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module wb_master
   import core_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                start_i,
   input  wire bus_req_t      req_i,
   input  wire                wb_ack_i,
   input  wire [`XLEN-1:0]    wb_dat_i,
   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output logic               wb_we_o,
   output logic [`XLEN-3:0]   wb_adr_o,
   output logic [`XLEN-1:0]   wb_dat_o,
   output logic               done_o,
   output logic [`XLEN-1:0]   rdata_o
);

   bus_req_t req_q;
   logic     cyc_q;
   logic     ack_seen;

   // Acks outside an active cycle are ignored
   assign ack_seen = cyc_q && wb_ack_i;

   always_ff @(posedge clk) begin
      if (reset) begin
         cyc_q <= 1'b0;
         done_o <= 1'b0;
      end else begin
         done_o <= ack_seen;
         if (start_i) begin
            cyc_q <= 1'b1;
         end else if (ack_seen) begin
            cyc_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start_i) begin
         req_q <= req_i;
      end
      if (ack_seen && !req_q.we) begin
         rdata_o <= wb_dat_i;
      end
   end

   assign wb_cyc_o = cyc_q;
   assign wb_stb_o = cyc_q;
   assign wb_we_o = cyc_q && req_q.we;
   assign wb_adr_o = req_q.adr;
   assign wb_dat_o = req_q.wdata;

endmodule

`default_nettype wire

// ==== source/core_control.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module core_control
   import core_pkg::*;
(
   input  wire                 clk,
   input  wire                 reset,
   input  wire decoded_instr_t dec_i,
   input  wire                 bus_done_i,
   input  wire [`XLEN-1:0]     next_pc_i,
   input  wire [`XLEN-1:0]     reg_rs2_val_i,
   input  wire [`XLEN-1:0]     alu_result_i,
   output logic                bus_start_o,
   output bus_req_t            bus_req_o,
   output logic                decode_en_o,
   output logic                execute_en_o,
   output logic                reg_we_o,
   output logic [`XLEN-1:0]    pc_o
);

   ctrl_state_t      state_q;
   ctrl_state_t      state_d;
   logic             bus_busy_q;
   logic             fetch_start;
   logic             data_start;
   logic [`XLEN-1:0] fetch_pc;

   always_comb begin
      case (state_q)
         ST_FETCH:   state_d = bus_done_i ? ST_DECODE : ST_FETCH;
         ST_DECODE:  state_d = ST_EXECUTE;
         ST_EXECUTE: state_d = (dec_i.mem_kind != MEM_NONE) ? ST_MEMORY : ST_WRITEBACK;
         ST_MEMORY:  state_d = bus_done_i ? ST_WRITEBACK : ST_MEMORY;
         default:    state_d = ST_FETCH;
      endcase
   end

   // =========================================================================
   // Bus requests
   // =========================================================================

   // Next fetch goes out as the current instruction finishes
   assign data_start = (state_q == ST_MEMORY) && !bus_busy_q;
   assign fetch_start = ((state_q == ST_FETCH) && !bus_busy_q) ||
                        ((state_q == ST_WRITEBACK) && dec_i.mem_kind == MEM_NONE) ||
                        ((state_q == ST_MEMORY) && bus_done_i);
   assign fetch_pc = (state_q == ST_FETCH) ? pc_o : next_pc_i;
   assign bus_start_o = fetch_start || data_start;

   always_comb begin
      if (data_start) begin
         bus_req_o.adr = alu_result_i[`XLEN-1:2];
         bus_req_o.wdata = reg_rs2_val_i;
         bus_req_o.we = (dec_i.mem_kind == MEM_STORE);
      end else begin
         bus_req_o.adr = fetch_pc[`XLEN-1:2];
         bus_req_o.wdata = '0;
         bus_req_o.we = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= ST_FETCH;
         bus_busy_q <= 1'b0;
         pc_o <= `RESET_VECTOR;
      end else begin
         state_q <= state_d;
         if (bus_start_o) begin
            bus_busy_q <= 1'b1;
         end else if (bus_done_i) begin
            bus_busy_q <= 1'b0;
         end
         if (state_q == ST_WRITEBACK) begin
            pc_o <= next_pc_i;
         end
      end
   end

   assign decode_en_o = (state_q == ST_DECODE);
   assign execute_en_o = (state_q == ST_EXECUTE);
   assign reg_we_o = (state_q == ST_WRITEBACK) && (dec_i.rd != '0) &&
                     (dec_i.wb_src != WB_NONE);

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module cpu_top
   import core_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                wb_ack_i,
   input  wire [`XLEN-1:0]    wb_dat_i,
   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output logic               wb_we_o,
   output logic [`XLEN-3:0]   wb_adr_o,
   output logic [`XLEN-1:0]   wb_dat_o
);

   decoded_instr_t   dec;
   bus_req_t         bus_req;
   logic             bus_start;
   logic             bus_done;
   logic [`XLEN-1:0] bus_rdata;
   logic             decode_en;
   logic             execute_en;
   logic             reg_we;
   logic [`XLEN-1:0] pc;
   logic [`XLEN-1:0] next_pc;
   logic [`XLEN-1:0] rs1_val;
   logic [`XLEN-1:0] rs2_val;
   logic [`XLEN-1:0] alu_result;
   logic             branch_taken;
   logic [`XLEN-1:0] reg_wdata;

   core_control u_control (
      .clk           (clk),
      .reset         (reset),
      .dec_i         (dec),
      .bus_done_i    (bus_done),
      .next_pc_i     (next_pc),
      .reg_rs2_val_i (rs2_val),
      .alu_result_i  (alu_result),
      .bus_start_o   (bus_start),
      .bus_req_o     (bus_req),
      .decode_en_o   (decode_en),
      .execute_en_o  (execute_en),
      .reg_we_o      (reg_we),
      .pc_o          (pc)
   );

   wb_master u_bus (
      .clk      (clk),
      .reset    (reset),
      .start_i  (bus_start),
      .req_i    (bus_req),
      .wb_ack_i (wb_ack_i),
      .wb_dat_i (wb_dat_i),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_we_o  (wb_we_o),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .done_o   (bus_done),
      .rdata_o  (bus_rdata)
   );

   // Fetched word sits in the bus read latch during DECODE
   instr_decode u_decode (
      .clk     (clk),
      .reset   (reset),
      .en_i    (decode_en),
      .instr_i (bus_rdata),
      .dec_o   (dec)
   );

   register_file u_regs (
      .clk       (clk),
      .we_i      (reg_we),
      .rd_i      (dec.rd),
      .wdata_i   (reg_wdata),
      .rs1_i     (dec.rs1),
      .rs2_i     (dec.rs2),
      .rs1_val_o (rs1_val),
      .rs2_val_o (rs2_val)
   );

   alu_execute u_execute (
      .clk            (clk),
      .en_i           (execute_en),
      .dec_i          (dec),
      .rs1_val_i      (rs1_val),
      .rs2_val_i      (rs2_val),
      .result_o       (alu_result),
      .branch_taken_o (branch_taken)
   );

   writeback_select u_result (
      .dec_i          (dec),
      .pc_i           (pc),
      .alu_result_i   (alu_result),
      .branch_taken_i (branch_taken),
      .load_data_i    (bus_rdata),
      .wdata_o        (reg_wdata),
      .next_pc_o      (next_pc)
   );

endmodule

`default_nettype wire

// ==== testbench/cpu_checker.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module cpu_checker (
   input wire              clk,
   input wire              reset,
   input wire              cyc_i,
   input wire              stb_i,
   input wire              we_i,
   input wire [`XLEN-3:0]  adr_i,
   input wire [`XLEN-1:0]  dat_i,
   input wire              ack_i
);

   // Cycle drops on the edge after its ack
   ack_ends_cycle: assert property (@(posedge clk) disable iff (reset)
      (cyc_i && stb_i && ack_i) |=> (!cyc_i && !stb_i))
      else $error("wishbone cycle still active after ack");

   // Request held unchanged until acknowledged
   request_stable: assert property (@(posedge clk) disable iff (reset)
      (cyc_i && !ack_i) |=> (cyc_i && $stable(adr_i) && $stable(dat_i) && $stable(we_i)))
      else $error("wishbone request changed or dropped before ack");

   reset_idle: assert property (@(posedge clk)
      reset |=> (!cyc_i && !stb_i && !we_i))
      else $error("wishbone cycle active during reset");

endmodule

bind wb_master cpu_checker u_checker (
   .clk   (clk),
   .reset (reset),
   .cyc_i (wb_cyc_o),
   .stb_i (wb_stb_o),
   .we_i  (wb_we_o),
   .adr_i (wb_adr_o),
   .dat_i (wb_dat_o),
   .ack_i (wb_ack_i)
);

`default_nettype wire

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/100ps
`include "cpu_params.svh"
`default_nettype none

module tb_cpu
   import core_pkg::*;
();

   localparam int RUN_LENGTH = 2000;
   localparam int CLK_PERIOD = 20;

   logic             clk;
   logic             reset;
   logic             wb_ack_i;
   logic [`XLEN-1:0] wb_dat_i;
   wire              wb_cyc_o;
   wire              wb_stb_o;
   wire              wb_we_o;
   wire [`XLEN-3:0]  wb_adr_o;
   wire [`XLEN-1:0]  wb_dat_o;

   logic [31:0] lfsr_state;
   logic [31:0] mem [0:255];
   logic [31:0] model_mem [0:255];
   logic [31:0] model_regs [0:31];
   logic [31:0] model_pc;
   int          fetch_count;

   cpu_top uut (
      .clk      (clk),
      .reset    (reset),
      .wb_ack_i (wb_ack_i),
      .wb_dat_i (wb_dat_i),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_we_o  (wb_we_o),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o)
   );

   // =========================================================================
   // Random source and failure reporting
   // =========================================================================

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic stop_on_failure(input string line);
      $display("%s", line);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_fetch(input bus_req_t got, input bus_req_t exp);
      if (got !== exp) begin
         stop_on_failure($sformatf("CHECK FAILED at %0t: fetch adr %h we %b, expected adr %h",
                                   $time, got.adr, got.we, exp.adr));
      end
   endtask

   task automatic check_load(input bus_req_t got, input bus_req_t exp);
      if (got.adr !== exp.adr || got.we !== 1'b0) begin
         stop_on_failure($sformatf("CHECK FAILED at %0t: load adr %h we %b, expected adr %h",
                                   $time, got.adr, got.we, exp.adr));
      end
   endtask

   task automatic check_store(input bus_req_t got, input bus_req_t exp);
      if (got !== exp) begin
         stop_on_failure($sformatf(
            "CHECK FAILED at %0t: store adr %h data %h we %b, expected adr %h data %h",
            $time, got.adr, got.wdata, got.we, exp.adr, exp.wdata));
      end
   endtask

   // =========================================================================
   // Program generation
   // =========================================================================

   function automatic logic [31:0] gen_instr();
      logic [31:0] kind;
      logic [31:0] rd;
      logic [31:0] rs1;
      logic [31:0] rs2;
      logic [31:0] imm;
      logic [31:0] sel;
      logic [31:0] alt;
      logic [2:0]  f3;
      logic [12:0] boff;
      logic [31:0] w;
      kind = random_bits(4);
      rd = random_bits(3);
      rs1 = random_bits(3);
      rs2 = random_bits(3);
      imm = random_bits(12);
      sel = random_bits(3);
      f3 = sel[2:0];
      case (kind[3:0])
         4'd0, 4'd1, 4'd2: begin
            alt = random_bits(1);
            w = {(f3 == 3'b000 && alt[0]) ? 7'b0100000 : 7'b0000000, rs2[4:0], rs1[4:0],
                 f3, rd[4:0], 7'b0110011};
         end
         4'd3, 4'd4: begin
            // No immediate shifts in the subset
            if (f3 == 3'b001 || f3 == 3'b101) begin
               f3 = {f3[2], 2'b00};
            end
            w = {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
         end
         4'd5: begin
            imm = random_bits(20);
            w = {imm[19:0], rd[4:0], 7'b0110111};
         end
         4'd6, 4'd7: begin
            if (f3 == 3'b010 || f3 == 3'b011) begin
               f3 = {2'b00, f3[0]};
            end
            alt = random_bits(4);
            boff = {{7{alt[3]}}, alt[3:0], 2'b00};
            if (boff == 13'd0) begin
               boff = 13'd8;
            end
            w = {boff[12], boff[10:5], rs2[4:0], rs1[4:0], f3, boff[4:1], boff[11],
                 7'b1100011};
         end
         4'd8, 4'd9: begin
            w = {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
         end
         4'd10, 4'd11, 4'd12, 4'd13: begin
            w = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
         end
         default: begin
            w = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
         end
      endcase
      return w;
   endfunction

   // =========================================================================
   // ISA model
   // =========================================================================

   function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return {31'd0, $signed(a) < $signed(b)};
         3'b011:  return {31'd0, a < b};
         3'b100:  return a ^ b;
         3'b101:  return a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic write_reg(input logic [4:0] rd, input logic [31:0] value);
      if (rd != 5'd0) begin
         model_regs[rd] = value;
      end
   endtask

   task automatic run_model(input logic [31:0] w, output logic data_access,
                            output bus_req_t exp_data);
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      logic [31:0] imm_b;
      logic [31:0] addr;
      logic [31:0] next_pc;
      logic        taken;
      f3 = w[14:12];
      f7 = w[31:25];
      a = model_regs[w[19:15]];
      b = model_regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      next_pc = model_pc + 32'd4;
      data_access = 1'b0;
      exp_data = '0;
      taken = 1'b0;
      case (w[6:0])
         7'b0110011: begin
            if (f7 == 7'b0000000 || (f7 == 7'b0100000 && f3 == 3'b000)) begin
               write_reg(w[11:7], alu_model(f3, f7[5], a, b));
            end
         end
         7'b0010011: begin
            if (f3 != 3'b001 && f3 != 3'b101) begin
               write_reg(w[11:7], alu_model(f3, 1'b0, a, imm_i));
            end
         end
         7'b0110111: write_reg(w[11:7], {w[31:12], 12'd0});
         7'b1100011: begin
            case (f3)
               3'b000:  taken = (a == b);
               3'b001:  taken = (a != b);
               3'b100:  taken = ($signed(a) < $signed(b));
               3'b101:  taken = ($signed(a) >= $signed(b));
               3'b110:  taken = (a < b);
               3'b111:  taken = (a >= b);
               default: taken = 1'b0;
            endcase
            if (taken) begin
               next_pc = model_pc + imm_b;
            end
         end
         7'b0000011: begin
            if (f3 == 3'b010) begin
               addr = a + imm_i;
               data_access = 1'b1;
               exp_data.adr = addr[31:2];
               write_reg(w[11:7], model_mem[addr[9:2]]);
            end
         end
         7'b0100011: begin
            if (f3 == 3'b010) begin
               addr = a + imm_s;
               data_access = 1'b1;
               exp_data.adr = addr[31:2];
               exp_data.wdata = b;
               exp_data.we = 1'b1;
               model_mem[addr[9:2]] = b;
            end
         end
         default: ;
      endcase
      model_pc = next_pc;
   endtask

   // =========================================================================
   // Clock, reset, memory slave
   // =========================================================================

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      logic [31:0] imm;
      reset = 1'b1;
      wb_ack_i = 1'b0;
      wb_dat_i = '0;
      lfsr_state = 32'h3395;
      fetch_count = 0;
      model_pc = `RESET_VECTOR;
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      // Give x1..x7 defined values before random code runs
      for (int i = 0; i < 7; i++) begin
         imm = random_bits(12);
         mem[i] = {imm[11:0], 5'd0, 3'b000, 5'(i + 1), 7'b0010011};
      end
      for (int i = 7; i < 256; i++) begin
         mem[i] = gen_instr();
      end
      for (int i = 0; i < 256; i++) begin
         model_mem[i] = mem[i];
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

   initial begin
      bus_req_t got;
      bus_req_t req_q;
      bus_req_t exp_fetch;
      bus_req_t exp_data;
      logic     expect_data;
      logic     in_req;
      logic     [31:0] wait_left;
      expect_data = 1'b0;
      in_req = 1'b0;
      wait_left = '0;
      exp_data = '0;
      forever begin
         @(negedge clk);
         if (reset) begin
            wb_ack_i = 1'b0;
            if (wb_cyc_o !== 1'b0 || wb_stb_o !== 1'b0 || wb_we_o !== 1'b0) begin
               stop_on_failure("Bus signals were not idle during reset");
            end
         end else if (wb_stb_o !== wb_cyc_o) begin
            stop_on_failure("Wishbone stb and cyc were not asserted together");
         end else if (wb_ack_i) begin
            wb_ack_i = 1'b0;
            in_req = 1'b0;
         end else if (wb_cyc_o) begin
            if (!in_req) begin
               in_req = 1'b1;
               wait_left = random_bits(2);
               got.adr = wb_adr_o;
               got.wdata = wb_dat_o;
               got.we = wb_we_o;
               req_q = got;
               if (expect_data) begin
                  if (exp_data.we) begin
                     check_store(got, exp_data);
                  end else begin
                     check_load(got, exp_data);
                  end
                  expect_data = 1'b0;
               end else begin
                  exp_fetch.adr = model_pc[31:2];
                  exp_fetch.wdata = '0;
                  exp_fetch.we = 1'b0;
                  check_fetch(got, exp_fetch);
                  fetch_count++;
                  run_model(model_mem[model_pc[9:2]], expect_data, exp_data);
               end
            end
            if (wait_left == 32'd0) begin
               wb_ack_i = 1'b1;
               wb_dat_i = mem[req_q.adr[7:0]];
               if (req_q.we) begin
                  mem[req_q.adr[7:0]] = req_q.wdata;
               end
            end else begin
               wait_left = wait_left - 32'd1;
            end
         end else if (in_req) begin
            stop_on_failure("Bus cycle ended before the slave acknowledged it");
         end
      end
   end

   initial begin
      #(RUN_LENGTH * 20 * CLK_PERIOD);
      $display("Timeout: the core stopped making progress on the bus");
      $display("test failed");
      $fatal(1);
   end

   initial begin
      wait (fetch_count > RUN_LENGTH);
      @(negedge clk);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/instr_decode.sv
source/register_file.sv
source/alu_execute.sv
source/writeback_select.sv
source/wb_master.sv
source/core_control.sv
source/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f project.f -o sim_tb_cpu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb_cpu)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "test passed"; then
   exit 0
fi
exit 1
